/* source/asi_defines.svh */
`ifndef ASI_DEFINES_SVH
`define ASI_DEFINES_SVH

// ----------------------------------------
// AXI bus widths
// ----------------------------------------

// Data bus width in bits
`define ASI_DW 64
// Address width
`define ASI_AW 32
// ID tag width
`define ASI_IW 4
// Burst length field width
`define ASI_LW 8
// Transfer size field width
`define ASI_SW 3
// Bytes per data word
`define ASI_BYTES 8

// ----------------------------------------
// Buffer depths and memory timing
// ----------------------------------------

// Outstanding read addresses
`define ASI_OD 4
// R buffer depth, also the credit count after reset
`define ASI_RD 16
// Memory wait states, at least one
`define ASI_WS 2

// Bursts may not cross a 4 KB page
`define ASI_BOUND_BIT 12

`endif

/* source/asi_pkg.sv */
`include "asi_defines.svh"

package asi_pkg;

    // ----------------------------------------
    // Encodings
    // ----------------------------------------

    // AXI burst type, WRAP handled like INCR
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10,
        RSVD  = 2'b11
    } burst_e;

    // Read response, only the two used codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    // Burst phase of the generator
    typedef enum logic [1:0] {
        FIRST = 2'b00,
        BURST = 2'b01,
        IDLE  = 2'b10
    } phase_e;

    // ----------------------------------------
    // Payload structs
    // ----------------------------------------

    // One AR request as held in the AR buffer
    typedef struct packed {
        logic [`ASI_IW-1:0] id;
        logic [`ASI_AW-1:0] addr;
        logic [`ASI_LW-1:0] len;
        logic [`ASI_SW-1:0] size;
        burst_e             burst;
    } ar_req_t;

    // One memory read, one per beat
    typedef struct packed {
        logic [`ASI_AW-1:0] addr;
        logic [`ASI_SW-1:0] size;
        logic               last;
    } mem_req_t;

    // Side info that follows a beat through the memory latency
    typedef struct packed {
        logic [`ASI_IW-1:0] id;
        resp_e              resp;
        logic               last;
    } beat_tag_t;

    // One R channel beat as held in the R buffer
    typedef struct packed {
        logic [`ASI_IW-1:0] id;
        logic [`ASI_DW-1:0] data;
        resp_e              resp;
        logic               last;
    } r_beat_t;

endpackage

/* source/sync_fifo.sv */
module sync_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] wdata,
    output logic [WIDTH-1:0] rdata,
    output logic             full,
    output logic             empty
);

    // Pointer and occupancy widths
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_push;
    logic             do_pop;

    // Requests on a full or empty FIFO are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);

    // Show-ahead read, oldest entry on rdata
    assign rdata = mem[rd_ptr];

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // ----------------------------------------
    // Pointers and count
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Wrap at DEPTH, also for depths that are not a power of two
            if (do_push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keeps the count
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* source/burst_addr.sv */
`include "asi_defines.svh"

module burst_addr
    import asi_pkg::*;
(
    input  ar_req_t            req,
    input  phase_e             phase,
    input  logic [`ASI_AW-1:0] cur_addr,
    output logic [`ASI_AW-1:0] beat_addr,
    output logic [`ASI_AW-1:0] next_addr,
    output logic               size_err,
    output logic               cross_4kb
);

    logic [`ASI_AW-1:0] align_mask;
    logic [`ASI_AW-1:0] aligned_addr;
    logic [`ASI_AW-1:0] incr;
    logic [`ASI_AW-1:0] base_addr;
    logic [`ASI_AW-1:0] raw_next;

    // ----------------------------------------
    // Transfer size
    // ----------------------------------------

    // Size wider than the data bus
    assign size_err = (req.size > $clog2(`ASI_BYTES));

    // Start address aligned down to the transfer size
    assign align_mask   = {`ASI_AW{1'b1}} << req.size;
    assign aligned_addr = req.addr & align_mask;

    // FIXED stays on one address, INCR and WRAP step by the size
    always_comb begin
        if (req.burst == FIXED) begin
            incr = '0;
        end else begin
            incr = {{(`ASI_AW - 1){1'b0}}, 1'b1} << req.size;
        end
    end

    // ----------------------------------------
    // Beat and next address
    // ----------------------------------------

    // First beat uses the address as given, possibly unaligned
    assign beat_addr = (phase == FIRST) ? req.addr : cur_addr;

    // Later beats step from the aligned start
    assign base_addr = (phase == FIRST) ? aligned_addr : cur_addr;
    assign raw_next  = base_addr + incr;

    // Leaving the 4 KB page flips the boundary bit
    assign cross_4kb = (raw_next[`ASI_BOUND_BIT] != req.addr[`ASI_BOUND_BIT]);

    // Hold at the last in-page address
    assign next_addr = cross_4kb ? base_addr : raw_next;

endmodule

/* source/burst_gen.sv */
`include "asi_defines.svh"

module burst_gen
    import asi_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  ar_req_t   ar_head,
    input  logic      ar_empty,
    output logic      ar_pop,
    input  logic      credit_return,
    output mem_req_t  mem_req,
    output logic      mem_re,
    output beat_tag_t tag,
    output logic      tag_valid,
    output logic      error_4kb
);

    phase_e                      phase;
    phase_e                      phase_nxt;
    ar_req_t                     req_q;
    ar_req_t                     cur_req;
    logic [`ASI_LW-1:0]          beat_cnt;
    logic [`ASI_AW-1:0]          cur_addr;
    logic [$clog2(`ASI_RD+1)-1:0] credit;
    logic                        have_credit;
    logic                        issue;
    logic                        beat_last;
    logic [`ASI_AW-1:0]          beat_addr;
    logic [`ASI_AW-1:0]          next_addr;
    logic                        size_err;
    logic                        cross_4kb;

    // ----------------------------------------
    // Issue decision
    // ----------------------------------------

    // One credit per R buffer slot still free
    assign have_credit = (credit != '0);

    // First beat needs a queued request, later beats only a credit
    always_comb begin
        case (phase)
            FIRST:   issue = !ar_empty && have_credit;
            BURST:   issue = have_credit;
            default: issue = 1'b0;
        endcase
    end

    // Head of the AR buffer in FIRST, latched copy afterwards
    assign cur_req = (phase == FIRST) ? ar_head : req_q;

    // Beat len is the last one
    assign beat_last = (phase == FIRST) ? (ar_head.len == '0) : (beat_cnt == req_q.len);

    assign ar_pop = (phase == FIRST) && issue;

    // ----------------------------------------
    // Address path
    // ----------------------------------------
    burst_addr u_burst_addr (
        .req       (cur_req),
        .phase     (phase),
        .cur_addr  (cur_addr),
        .beat_addr (beat_addr),
        .next_addr (next_addr),
        .size_err  (size_err),
        .cross_4kb (cross_4kb)
    );

    // Memory request and the matching tag
    assign mem_re       = issue;
    assign mem_req.addr = beat_addr;
    assign mem_req.size = cur_req.size;
    assign mem_req.last = beat_last;

    assign tag_valid = issue;
    assign tag.id    = cur_req.id;
    assign tag.resp  = size_err ? SLVERR : OKAY;
    assign tag.last  = beat_last;

    // One pulse per following beat held at the page edge
    assign error_4kb = issue && cross_4kb && !beat_last;

    // ----------------------------------------
    // Phase FSM
    // ----------------------------------------
    always_comb begin
        phase_nxt = phase;
        case (phase)
            IDLE:  phase_nxt = FIRST;
            FIRST: begin
                // Single-beat bursts stay in FIRST
                if (issue && !beat_last) begin
                    phase_nxt = BURST;
                end
            end
            BURST: begin
                if (issue && beat_last) begin
                    phase_nxt = FIRST;
                end
            end
            default: phase_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= IDLE;
            beat_cnt <= '0;
            cur_addr <= '0;
            credit   <= `ASI_RD;
        end else begin
            phase <= phase_nxt;
            if (issue) begin
                // Beat 1 follows the first beat
                beat_cnt <= (phase == FIRST) ? 1 : beat_cnt + 1'b1;
                cur_addr <= next_addr;
            end
            // Spend on issue, refund on R handshake
            credit <= credit - mem_re + credit_return;
        end
    end

    // Request of the burst in progress
    always_ff @(posedge clk) begin
        if (ar_pop) begin
            req_q <= ar_head;
        end
    end

endmodule

/* source/resp_delay.sv */
`include "asi_defines.svh"

module resp_delay
    import asi_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  beat_tag_t tag_in,
    input  logic      valid_in,
    output beat_tag_t tag_out,
    output logic      valid_out
);

    // One stage per memory wait state
    beat_tag_t         tag_q [`ASI_WS];
    logic [`ASI_WS-1:0] vld_q;

    // ----------------------------------------
    // Valid bits
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= valid_in;
            for (int i = 1; i < `ASI_WS; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // Tag payload shifts alongside
    always_ff @(posedge clk) begin
        tag_q[0] <= tag_in;
        for (int i = 1; i < `ASI_WS; i++) begin
            tag_q[i] <= tag_q[i-1];
        end
    end

    // Oldest stage lines up with the memory data
    assign tag_out   = tag_q[`ASI_WS-1];
    assign valid_out = vld_q[`ASI_WS-1];

endmodule

/* source/asi_read.sv */
`include "asi_defines.svh"

module asi_read
    import asi_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    // AR channel
    input  logic [`ASI_IW-1:0] ar_id,
    input  logic [`ASI_AW-1:0] ar_addr,
    input  logic [`ASI_LW-1:0] ar_len,
    input  logic [`ASI_SW-1:0] ar_size,
    input  logic [1:0]         ar_burst,
    input  logic               ar_valid,
    output logic               ar_ready,
    // R channel
    output logic [`ASI_IW-1:0] r_id,
    output logic [`ASI_DW-1:0] r_data,
    output logic [1:0]         r_resp,
    output logic               r_last,
    output logic               r_valid,
    input  logic               r_ready,
    // Memory side
    output mem_req_t           mem_req,
    output logic               mem_re,
    input  logic [`ASI_DW-1:0] mem_rdata,
    input  logic               mem_rvalid,
    output logic               error_4kb
);

    ar_req_t   ar_in;
    logic [$bits(ar_req_t)-1:0] ar_q;
    ar_req_t   ar_head;
    logic      ar_full;
    logic      ar_empty;
    logic      ar_push;
    logic      ar_pop;
    beat_tag_t tag;
    logic      tag_valid;
    beat_tag_t dly_tag;
    logic      dly_valid;
    r_beat_t   r_in;
    logic [$bits(r_beat_t)-1:0] r_q;
    r_beat_t   r_head;
    logic      r_push;
    logic      r_pop;
    logic      r_empty;

    // ----------------------------------------
    // AR buffer
    // ----------------------------------------
    assign ar_in.id    = ar_id;
    assign ar_in.addr  = ar_addr;
    assign ar_in.len   = ar_len;
    assign ar_in.size  = ar_size;
    assign ar_in.burst = burst_e'(ar_burst);

    assign ar_ready = !ar_full;
    assign ar_push  = ar_valid && ar_ready;

    sync_fifo #(
        .DEPTH (`ASI_OD),
        .WIDTH ($bits(ar_req_t))
    ) u_ar_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (ar_push),
        .pop   (ar_pop),
        .wdata (ar_in),
        .rdata (ar_q),
        .full  (ar_full),
        .empty (ar_empty)
    );

    assign ar_head = ar_q;

    // ----------------------------------------
    // Beat generation and tag delay
    // ----------------------------------------
    burst_gen u_burst_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .ar_head       (ar_head),
        .ar_empty      (ar_empty),
        .ar_pop        (ar_pop),
        .credit_return (r_pop),
        .mem_req       (mem_req),
        .mem_re        (mem_re),
        .tag           (tag),
        .tag_valid     (tag_valid),
        .error_4kb     (error_4kb)
    );

    resp_delay u_resp_delay (
        .clk       (clk),
        .rst_n     (rst_n),
        .tag_in    (tag),
        .valid_in  (tag_valid),
        .tag_out   (dly_tag),
        .valid_out (dly_valid)
    );

    // ----------------------------------------
    // R buffer
    // ----------------------------------------

    // Memory data joins its delayed tag
    assign r_in.id   = dly_tag.id;
    assign r_in.data = mem_rdata;
    assign r_in.resp = dly_tag.resp;
    assign r_in.last = dly_tag.last;

    // Credits keep this from ever seeing a full buffer
    assign r_push = mem_rvalid && dly_valid;
    assign r_pop  = r_valid && r_ready;

    sync_fifo #(
        .DEPTH (`ASI_RD),
        .WIDTH ($bits(r_beat_t))
    ) u_r_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (r_push),
        .pop   (r_pop),
        .wdata (r_in),
        .rdata (r_q),
        .full  (),
        .empty (r_empty)
    );

    assign r_head = r_q;

    // R channel ports from the buffer head
    assign r_valid = !r_empty;
    assign r_id    = r_head.id;
    assign r_data  = r_head.data;
    assign r_resp  = r_head.resp;
    assign r_last  = r_head.last;

endmodule

/* bench/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ----------------------------------------
// Memory contents
// ----------------------------------------

// Data word as a function of the whole word address
function automatic logic [`ASI_DW-1:0] word_data(input logic [`ASI_AW-1:0] addr);
    logic [`ASI_AW-1:0] wa;
    wa = addr & ~(`ASI_AW'(`ASI_BYTES - 1));
    return {wa ^ 32'h5ac3_96e1, ~wa + 32'h1357_9bdf};
endfunction

// ----------------------------------------
// Beat address rules
// ----------------------------------------

// Zero for FIXED, bytes per transfer otherwise
function automatic logic [`ASI_AW-1:0] beat_step(input logic [`ASI_SW-1:0] size,
                                                 input logic [1:0] burst);
    if (burst == FIXED) begin
        return '0;
    end
    return `ASI_AW'(1) << size;
endfunction

// Start address aligned down to the transfer size
function automatic logic [`ASI_AW-1:0] aligned_start(input logic [`ASI_AW-1:0] addr,
                                                     input logic [`ASI_SW-1:0] size);
    return addr & ({`ASI_AW{1'b1}} << size);
endfunction

// Address of beat k, held at the last in-page address past a 4 KB edge
function automatic logic [`ASI_AW-1:0] ref_addr(input logic [`ASI_AW-1:0] addr,
                                                input logic [`ASI_SW-1:0] size,
                                                input logic [1:0] burst, input int k);
    logic [`ASI_AW-1:0] cur;
    logic [`ASI_AW-1:0] base;
    logic [`ASI_AW-1:0] nxt;
    cur = addr;
    for (int i = 0; i < k; i++) begin
        base = (i == 0) ? aligned_start(addr, size) : cur;
        nxt  = base + beat_step(size, burst);
        cur  = (nxt[`ASI_BOUND_BIT] != addr[`ASI_BOUND_BIT]) ? base : nxt;
    end
    return cur;
endfunction

// Non-last beats whose next address leaves the page
function automatic int ref_cross_count(input logic [`ASI_AW-1:0] addr,
                                       input logic [`ASI_SW-1:0] size,
                                       input logic [1:0] burst, input int len);
    logic [`ASI_AW-1:0] base;
    logic [`ASI_AW-1:0] nxt;
    int                 n;
    n = 0;
    for (int i = 0; i < len; i++) begin
        base = (i == 0) ? aligned_start(addr, size) : ref_addr(addr, size, burst, i);
        nxt  = base + beat_step(size, burst);
        if (nxt[`ASI_BOUND_BIT] != addr[`ASI_BOUND_BIT]) begin
            n++;
        end
    end
    return n;
endfunction

// Full expected R beat k of one request
function automatic r_beat_t ref_beat(input logic [`ASI_IW-1:0] id,
                                     input logic [`ASI_AW-1:0] addr,
                                     input logic [`ASI_LW-1:0] len,
                                     input logic [`ASI_SW-1:0] size,
                                     input logic [1:0] burst, input int k);
    r_beat_t b;
    b.id   = id;
    b.data = word_data(ref_addr(addr, size, burst, k));
    // Size wider than the bus gives SLVERR
    b.resp = (size > $clog2(`ASI_BYTES)) ? SLVERR : OKAY;
    b.last = (k == int'(len));
    return b;
endfunction

`endif

/* bench/tb_asi_read.sv */
`include "asi_defines.svh"

module tb_asi_read
    import asi_pkg::*;
();

    logic               clk;
    logic               rst_n;
    logic [`ASI_IW-1:0] ar_id;
    logic [`ASI_AW-1:0] ar_addr;
    logic [`ASI_LW-1:0] ar_len;
    logic [`ASI_SW-1:0] ar_size;
    logic [1:0]         ar_burst;
    logic               ar_valid;
    logic               ar_ready;
    logic [`ASI_IW-1:0] r_id;
    logic [`ASI_DW-1:0] r_data;
    logic [1:0]         r_resp;
    logic               r_last;
    logic               r_valid;
    logic               r_ready;
    mem_req_t           mem_req;
    logic               mem_re;
    logic [`ASI_DW-1:0] mem_rdata;
    logic               mem_rvalid;
    logic               error_4kb;

    // Expected beats in acceptance order
    r_beat_t            exp_q [$];
    // Expected memory reads in issue order
    mem_req_t           exp_mem_q [$];
    int                 checks       = 0;
    int                 value_errors = 0;
    int                 other_errors = 0;
    int                 err4k_seen   = 0;
    int                 err4k_exp    = 0;
    int                 re_seen      = 0;
    // R ready control
    bit                 rand_ready   = 1'b0;
    bit                 ready_level  = 1'b0;
    logic [1023:0]      ready_pat;
    // Memory latency pipeline
    logic               pipe_v [`ASI_WS+1];
    logic [`ASI_AW-1:0] pipe_a [`ASI_WS+1];

    `include "tb_ref_model.svh"

    asi_read u_asi_read (
        .clk        (clk),
        .rst_n      (rst_n),
        .ar_id      (ar_id),
        .ar_addr    (ar_addr),
        .ar_len     (ar_len),
        .ar_size    (ar_size),
        .ar_burst   (ar_burst),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .r_id       (r_id),
        .r_data     (r_data),
        .r_resp     (r_resp),
        .r_last     (r_last),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .mem_req    (mem_req),
        .mem_re     (mem_re),
        .mem_rdata  (mem_rdata),
        .mem_rvalid (mem_rvalid),
        .error_4kb  (error_4kb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic report_and_finish();
        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        other_errors++;
        $display("Error: timed out waiting for %s", what);
        report_and_finish();
    endtask

    // Present one request and queue its beats once accepted
    task automatic send_req(input logic [`ASI_IW-1:0] id, input logic [`ASI_AW-1:0] addr,
                            input logic [`ASI_LW-1:0] len, input logic [`ASI_SW-1:0] size,
                            input logic [1:0] burst);
        int       n;
        mem_req_t m;
        n = 0;
        @(negedge clk);
        ar_id    = id;
        ar_addr  = addr;
        ar_len   = len;
        ar_size  = size;
        ar_burst = burst;
        ar_valid = 1'b1;
        forever begin
            @(posedge clk);
            if (ar_ready) begin
                break;
            end
            n++;
            if (n > 500) begin
                abort_on_timeout("ar_ready");
            end
        end
        for (int k = 0; k <= int'(len); k++) begin
            exp_q.push_back(ref_beat(id, addr, len, size, burst, k));
            m.addr = ref_addr(addr, size, burst, k);
            m.size = size;
            m.last = (k == int'(len));
            exp_mem_q.push_back(m);
        end
        err4k_exp += ref_cross_count(addr, size, burst, int'(len));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            ar_valid = 1'b0;
        end
    endtask

    // Wait for all queued beats, then check the page-edge pulse count
    task automatic wait_drain();
        int n;
        n = 0;
        idle_cycles(1);
        while (exp_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > 3000) begin
                abort_on_timeout("all R beats");
            end
        end
        idle_cycles(`ASI_WS + 4);
        compare_value("r_valid", r_valid, 1'b0);
        compare_value("error_4kb pulses", err4k_seen, err4k_exp);
    endtask

    // ----------------------------------------
    // Memory model with fixed wait states
    // ----------------------------------------
    initial begin : memory_model
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        for (int i = 0; i <= `ASI_WS; i++) begin
            pipe_v[i] = 1'b0;
            pipe_a[i] = '0;
        end
        forever begin
            @(negedge clk);
            for (int i = `ASI_WS; i > 0; i--) begin
                pipe_v[i] = pipe_v[i-1];
                pipe_a[i] = pipe_a[i-1];
            end
            pipe_v[0]  = mem_re;
            pipe_a[0]  = mem_req.addr;
            mem_rvalid = pipe_v[`ASI_WS];
            mem_rdata  = pipe_v[`ASI_WS] ? word_data(pipe_a[`ASI_WS]) : '0;
        end
    end

    // R ready from a fixed random pattern or a level
    initial begin : ready_driver
        int cyc;
        cyc     = 0;
        r_ready = 1'b0;
        forever begin
            @(negedge clk);
            r_ready = rand_ready ? ready_pat[cyc % 1024] : ready_level;
            cyc++;
        end
    end

    // ----------------------------------------
    // R monitor and event counters
    // ----------------------------------------
    always @(posedge clk) begin : monitor
        r_beat_t  exp;
        mem_req_t mreq;
        if (rst_n) begin
            if (r_valid && exp_q.size() == 0) begin
                other_errors++;
                $display("Error: r_valid high with no beat outstanding");
            end else if (r_valid && r_ready) begin
                exp = exp_q.pop_front();
                compare_value("r_id", r_id, exp.id);
                compare_value("r_data", r_data, exp.data);
                compare_value("r_resp", r_resp, exp.resp);
                compare_value("r_last", r_last, exp.last);
            end
            if (error_4kb) begin
                err4k_seen++;
            end
            if (mem_re) begin
                re_seen++;
                if (exp_mem_q.size() == 0) begin
                    other_errors++;
                    $display("Error: mem_re high with no memory read outstanding");
                end else begin
                    mreq = exp_mem_q.pop_front();
                    compare_value("mem_req.addr", mem_req.addr, mreq.addr);
                    compare_value("mem_req.size", mem_req.size, mreq.size);
                    compare_value("mem_req.last", mem_req.last, mreq.last);
                end
            end
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        int gap;
        int re_mark;
        void'($urandom(32'h055ff517));
        for (int i = 0; i < 32; i++) begin
            ready_pat[i*32 +: 32] = $urandom;
        end
        rst_n    = 1'b0;
        ar_id    = '0;
        ar_addr  = '0;
        ar_len   = '0;
        ar_size  = '0;
        ar_burst = '0;
        ar_valid = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n       = 1'b1;
        ready_level = 1'b1;

        // Aligned full-width INCR
        send_req(4'h1, 32'h0000_0100, 8'd0, 3'd3, INCR);
        send_req(4'h2, 32'h0000_0200, 8'd1, 3'd3, INCR);
        send_req(4'h3, 32'h0000_0300, 8'd7, 3'd3, INCR);
        wait_drain();

        // Narrow and unaligned starts
        send_req(4'h4, 32'h0000_0405, 8'd3, 3'd1, INCR);
        send_req(4'h5, 32'h0000_0513, 8'd5, 3'd2, INCR);
        send_req(4'h6, 32'h0000_0601, 8'd9, 3'd0, WRAP);
        send_req(4'h7, 32'h0000_070c, 8'd2, 3'd3, INCR);
        wait_drain();

        // FIXED bursts repeat one word
        send_req(4'h8, 32'h0000_0808, 8'd3, 3'd3, FIXED);
        send_req(4'h9, 32'h0000_090b, 8'd4, 3'd2, FIXED);
        wait_drain();

        // Sizes wider than the bus
        send_req(4'ha, 32'h0000_0a00, 8'd3, 3'd4, INCR);
        send_req(4'hb, 32'h0000_0b07, 8'd1, 3'd7, INCR);
        send_req(4'hc, 32'h0000_0c10, 8'd2, 3'd5, FIXED);
        wait_drain();

        // Back-pressure until credits run out and the AR buffer fills
        ready_level = 1'b0;
        re_mark     = re_seen;
        for (int i = 0; i < 6; i++) begin
            send_req(4'(i), 32'h0000_3000 + 32'(i) * 32'h40, 8'd7, 3'd3, INCR);
        end
        idle_cycles(20);
        compare_value("mem_re beats", re_seen - re_mark, `ASI_RD);
        compare_value("ar_ready", ar_ready, 1'b0);
        ready_level = 1'b1;
        wait_drain();

        // Random traffic with random r_ready
        rand_ready = 1'b1;
        for (int n = 0; n < 40; n++) begin
            gap = $urandom % 4;
            idle_cycles(gap);
            send_req(4'($urandom), 32'h0000_4000 + ($urandom % 32'h2000),
                     8'($urandom % 16), 3'($urandom % 4), 2'($urandom % 3));
        end
        wait_drain();
        rand_ready = 1'b0;

        // 4 KB page edge
        send_req(4'hd, 32'h0000_0fe0, 8'd7, 3'd3, INCR);
        send_req(4'he, 32'h0000_1ff9, 8'd5, 3'd1, INCR);
        send_req(4'hf, 32'h0000_2ff8, 8'd0, 3'd3, INCR);
        wait_drain();

        report_and_finish();
    end

endmodule

/* flist.f */
+incdir+source
+incdir+bench
source/asi_pkg.sv
source/sync_fifo.sv
source/burst_addr.sv
source/burst_gen.sv
source/resp_delay.sv
source/asi_read.sv
bench/tb_asi_read.sv
